/* ctrl_pkg.sv */
package ctrl_pkg;

    // Wait lengths in cycles
    localparam int unsigned FETCH_WAIT = 3;
    localparam int unsigned MEM_WAIT   = 2;
    localparam int unsigned EXC_WAIT   = 4;
    localparam int unsigned WAIT_W     = 3;     // Wide enough for the longest wait

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_LH    = 6'h21;
    localparam logic [5:0] OP_LB    = 6'h20;
    localparam logic [5:0] OP_SW    = 6'h2b;
    localparam logic [5:0] OP_SH    = 6'h29;
    localparam logic [5:0] OP_SB    = 6'h28;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_JAL   = 6'h03;

    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_JR  = 6'h08;

    typedef enum logic [4:0] {
        ST_FETCH,
        ST_FETCH_DONE,
        ST_DECODE,
        ST_DISPATCH,
        ST_EXEC,
        ST_WRITEBACK,
        ST_ADDR,
        ST_MEM_READ,
        ST_MDR_SELECT,
        ST_LOAD_WRITE,
        ST_STORE,
        ST_JUMP,
        ST_JAL_CALC,
        ST_JAL_LINK,
        ST_JR,
        ST_EXC_ILLEGAL,
        ST_EXC_OVERFLOW,
        ST_EXC_COMMIT
    } state_t;

    typedef enum logic [3:0] {
        CL_RALU,
        CL_ADDI,
        CL_ADDIU,
        CL_LOAD,
        CL_STORE,
        CL_J,
        CL_JAL,
        CL_JR,
        CL_ILLEGAL
    } instr_class_t;

    typedef enum logic [1:0] {SZ_WORD = 2'd0, SZ_HALF = 2'd1, SZ_BYTE = 2'd2} access_size_t;

    typedef enum logic [2:0] {
        ALU_PASS = 3'd0,
        ALU_ADD  = 3'd1,
        ALU_SUB  = 3'd2,
        ALU_AND  = 3'd3
    } alu_op_t;

    typedef enum logic [1:0] {SRC_A_PC = 2'd0, SRC_A_REG = 2'd1} alu_src_a_t;

    typedef enum logic [2:0] {
        SRC_B_REG  = 3'd0,
        SRC_B_FOUR = 3'd1,
        SRC_B_IMM  = 3'd2
    } alu_src_b_t;

    typedef enum logic [2:0] {
        PC_SRC_ALU    = 3'd0,
        PC_SRC_JUMP   = 3'd2,
        PC_SRC_VECTOR = 3'd3
    } pc_src_t;

    typedef enum logic [2:0] {
        IORD_PC     = 3'd0,
        IORD_ALUOUT = 3'd1,
        IORD_VECTOR = 3'd2
    } iord_t;

    typedef enum logic [1:0] {
        DST_RT = 2'd0,
        DST_RD = 2'd1,
        DST_SP = 2'd2,
        DST_RA = 2'd3
    } reg_dst_t;

    typedef enum logic [3:0] {
        WD_ALUOUT  = 4'd0,
        WD_MDR     = 4'd1,
        WD_SP_INIT = 4'd4     // Stack top constant
    } mem_to_reg_t;

    typedef enum logic [1:0] {EXC_ILLEGAL = 2'd0, EXC_OVERFLOW = 2'd1} except_t;

    typedef struct packed {
        instr_class_t iclass;
        access_size_t size;
        alu_op_t      alu_op;
        logic         use_rd;   // R-type writes rd, the rest rt
    } decoded_op_t;

    typedef struct packed {
        logic    pc_write;
        logic    branch;
        pc_src_t pc_src;
    } pc_ctrl_t;

    typedef struct packed {
        logic         mem_wr;
        iord_t        iord;
        access_size_t mem_to_mdr;
        access_size_t b_to_c;
    } mem_ctrl_t;

    typedef struct packed {
        alu_src_a_t src_a;
        alu_src_b_t src_b;
        alu_op_t    op;
        logic       alu_out_write;
    } alu_ctrl_t;

    typedef struct packed {
        logic        ir_write;
        logic        a_write;
        logic        b_write;
        logic        mdr_write;
        logic        epc_write;
        logic        reg_write;
        reg_dst_t    reg_dst;
        mem_to_reg_t mem_to_reg;
    } reg_ctrl_t;

    typedef struct packed {
        pc_ctrl_t  pc;
        mem_ctrl_t mem;
        alu_ctrl_t alu;
        reg_ctrl_t regs;
        except_t   except;
    } ctrl_word_t;

    // Nothing written, nothing strobed
    localparam ctrl_word_t IDLE_WORD = '{
        pc:     '{pc_write: 1'b0, branch: 1'b0, pc_src: PC_SRC_ALU},
        mem:    '{mem_wr: 1'b0, iord: IORD_PC, mem_to_mdr: SZ_WORD, b_to_c: SZ_WORD},
        alu:    '{src_a: SRC_A_PC, src_b: SRC_B_REG, op: ALU_PASS, alu_out_write: 1'b0},
        regs:   '{ir_write: 1'b0, a_write: 1'b0, b_write: 1'b0, mdr_write: 1'b0,
                  epc_write: 1'b0, reg_write: 1'b0, reg_dst: DST_RT, mem_to_reg: WD_ALUOUT},
        except: EXC_ILLEGAL
    };

    // Read at PC while the ALU forms PC + 4
    localparam ctrl_word_t FETCH_WORD = '{
        pc:     '{pc_write: 1'b0, branch: 1'b0, pc_src: PC_SRC_ALU},
        mem:    '{mem_wr: 1'b0, iord: IORD_PC, mem_to_mdr: SZ_WORD, b_to_c: SZ_WORD},
        alu:    '{src_a: SRC_A_PC, src_b: SRC_B_FOUR, op: ALU_ADD, alu_out_write: 1'b0},
        regs:   '{ir_write: 1'b0, a_write: 1'b0, b_write: 1'b0, mdr_write: 1'b0,
                  epc_write: 1'b0, reg_write: 1'b0, reg_dst: DST_RT, mem_to_reg: WD_ALUOUT},
        except: EXC_ILLEGAL
    };

    localparam ctrl_word_t SP_INIT_WORD = '{
        pc:     '{pc_write: 1'b0, branch: 1'b0, pc_src: PC_SRC_ALU},
        mem:    '{mem_wr: 1'b0, iord: IORD_PC, mem_to_mdr: SZ_WORD, b_to_c: SZ_WORD},
        alu:    '{src_a: SRC_A_PC, src_b: SRC_B_REG, op: ALU_PASS, alu_out_write: 1'b0},
        regs:   '{ir_write: 1'b0, a_write: 1'b0, b_write: 1'b0, mdr_write: 1'b0,
                  epc_write: 1'b0, reg_write: 1'b1, reg_dst: DST_SP, mem_to_reg: WD_SP_INIT},
        except: EXC_ILLEGAL
    };

endpackage

/* ctrl_decode.sv */
module ctrl_decode import ctrl_pkg::*; (
    input  logic [5:0]  opcode,
    input  logic [5:0]  funct,
    output decoded_op_t op
);

    always_comb begin
        // Anything not matched below stays illegal
        op.iclass = CL_ILLEGAL;
        op.size   = SZ_WORD;
        op.alu_op = ALU_PASS;
        op.use_rd = 1'b0;

        case (opcode)
            OP_RTYPE: begin
                op.use_rd = 1'b1;
                case (funct)
                    FN_ADD: begin
                        op.iclass = CL_RALU;
                        op.alu_op = ALU_ADD;
                    end
                    FN_SUB: begin
                        op.iclass = CL_RALU;
                        op.alu_op = ALU_SUB;
                    end
                    FN_AND: begin
                        op.iclass = CL_RALU;
                        op.alu_op = ALU_AND;
                    end
                    FN_JR:   op.iclass = CL_JR;   // Target passes through the ALU
                    default: op.iclass = CL_ILLEGAL;
                endcase
            end
            OP_ADDI: begin
                op.iclass = CL_ADDI;
                op.alu_op = ALU_ADD;
            end
            OP_ADDIU: begin
                op.iclass = CL_ADDIU;
                op.alu_op = ALU_ADD;
            end
            OP_LW, OP_LH, OP_LB: begin
                op.iclass = CL_LOAD;
                op.alu_op = ALU_ADD;        // Base plus offset
            end
            OP_SW, OP_SH, OP_SB: begin
                op.iclass = CL_STORE;
                op.alu_op = ALU_ADD;
            end
            OP_J:    op.iclass = CL_J;
            OP_JAL:  op.iclass = CL_JAL;
            default: op.iclass = CL_ILLEGAL;
        endcase

        // Access size from the low opcode bits of the load/store group
        case (opcode)
            OP_LH, OP_SH: op.size = SZ_HALF;
            OP_LB, OP_SB: op.size = SZ_BYTE;
            default:      op.size = SZ_WORD;
        endcase
    end

endmodule

/* ctrl_sequencer.sv */
module ctrl_sequencer import ctrl_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  decoded_op_t dec_op,
    input  logic        ov,
    output state_t      state,
    output decoded_op_t op
);

    logic [WAIT_W-1:0] wait_cnt;
    logic [WAIT_W-1:0] next_cnt;
    state_t            next_state;
    logic              ov_trap;

    // True in the last cycle of a wait of len cycles
    function automatic logic wait_last(logic [WAIT_W-1:0] cnt, int unsigned len);
        return cnt == WAIT_W'(len - 1);
    endfunction

    // Only the signed adds trap
    assign ov_trap = ov && (op.iclass == CL_RALU || op.iclass == CL_ADDI);

    always_comb begin
        next_state = state;
        next_cnt   = '0;

        case (state)
            ST_FETCH: begin
                if (wait_last(wait_cnt, FETCH_WAIT)) begin
                    next_state = ST_FETCH_DONE;
                end else begin
                    next_cnt = wait_cnt + 1'b1;
                end
            end
            ST_FETCH_DONE: next_state = ST_DECODE;
            ST_DECODE:     next_state = ST_DISPATCH;
            ST_DISPATCH: begin
                case (dec_op.iclass)
                    CL_RALU, CL_ADDI, CL_ADDIU: next_state = ST_EXEC;
                    CL_LOAD, CL_STORE:          next_state = ST_ADDR;
                    CL_J:                       next_state = ST_JUMP;
                    CL_JAL:                     next_state = ST_JAL_CALC;
                    CL_JR:                      next_state = ST_JR;
                    default:                    next_state = ST_EXC_ILLEGAL;
                endcase
            end
            ST_EXEC: begin
                next_state = ov_trap ? ST_EXC_OVERFLOW : ST_WRITEBACK;
            end
            ST_ADDR: next_state = ST_MEM_READ;
            ST_MEM_READ: begin
                if (wait_last(wait_cnt, MEM_WAIT)) begin
                    next_state = (op.iclass == CL_LOAD) ? ST_MDR_SELECT : ST_STORE;
                end else begin
                    next_cnt = wait_cnt + 1'b1;
                end
            end
            ST_MDR_SELECT: next_state = ST_LOAD_WRITE;
            ST_JAL_CALC:   next_state = ST_JAL_LINK;
            ST_EXC_ILLEGAL, ST_EXC_OVERFLOW: begin
                // Handler vector is read during these cycles
                if (wait_last(wait_cnt, EXC_WAIT)) begin
                    next_state = ST_EXC_COMMIT;
                end else begin
                    next_cnt = wait_cnt + 1'b1;
                end
            end
            // Writeback, store, jumps and commit all end the instruction
            default: next_state = ST_FETCH;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ST_FETCH;
            wait_cnt <= '0;
        end else begin
            state    <= next_state;
            wait_cnt <= next_cnt;
        end
    end

    // Held until the next dispatch
    always_ff @(posedge clk) begin
        if (state == ST_DISPATCH) begin
            op <= dec_op;
        end
    end

endmodule

/* ctrl_outputs.sv */
module ctrl_outputs import ctrl_pkg::*; (
    input  logic        reset,
    input  state_t      state,
    input  decoded_op_t op,
    output ctrl_word_t  ctrl
);

    reg_dst_t wr_dst;

    assign wr_dst = op.use_rd ? DST_RD : DST_RT;

    always_comb begin
        ctrl = IDLE_WORD;

        if (reset) begin
            ctrl = SP_INIT_WORD;        // Stack top loaded while in reset
        end else begin
            case (state)
                ST_FETCH: ctrl = FETCH_WORD;
                ST_FETCH_DONE: begin
                    ctrl               = FETCH_WORD;
                    ctrl.pc.pc_write   = 1'b1;      // PC + 4 from the ALU
                    ctrl.regs.ir_write = 1'b1;
                end
                ST_DECODE: begin
                    ctrl.regs.a_write = 1'b1;
                    ctrl.regs.b_write = 1'b1;
                end
                ST_EXEC: begin
                    ctrl.alu.src_a         = SRC_A_REG;
                    ctrl.alu.src_b         = (op.iclass == CL_RALU) ? SRC_B_REG : SRC_B_IMM;
                    ctrl.alu.op            = op.alu_op;
                    ctrl.alu.alu_out_write = 1'b1;
                end
                ST_WRITEBACK: begin
                    ctrl.regs.reg_write  = 1'b1;
                    ctrl.regs.reg_dst    = wr_dst;
                    ctrl.regs.mem_to_reg = WD_ALUOUT;
                end
                ST_ADDR: begin
                    ctrl.alu.src_a         = SRC_A_REG;
                    ctrl.alu.src_b         = SRC_B_IMM;
                    ctrl.alu.op            = op.alu_op;
                    ctrl.alu.alu_out_write = 1'b1;  // Address kept in ALUOUT
                end
                ST_MEM_READ: ctrl.mem.iord = IORD_ALUOUT;
                ST_MDR_SELECT: begin
                    ctrl.mem.iord        = IORD_ALUOUT;
                    ctrl.mem.mem_to_mdr  = op.size;
                    ctrl.regs.mdr_write  = 1'b1;
                end
                ST_LOAD_WRITE: begin
                    ctrl.regs.reg_write  = 1'b1;
                    ctrl.regs.reg_dst    = wr_dst;
                    ctrl.regs.mem_to_reg = WD_MDR;
                end
                ST_STORE: begin
                    ctrl.mem.mem_wr = 1'b1;
                    ctrl.mem.iord   = IORD_ALUOUT;
                    ctrl.mem.b_to_c = op.size;
                end
                ST_JUMP: begin
                    ctrl.pc.pc_write = 1'b1;
                    ctrl.pc.branch   = 1'b1;
                    ctrl.pc.pc_src   = PC_SRC_JUMP;
                end
                ST_JAL_CALC: begin
                    ctrl.alu.src_a         = SRC_A_PC;
                    ctrl.alu.op            = ALU_PASS;
                    ctrl.alu.alu_out_write = 1'b1;  // Return address
                end
                ST_JAL_LINK: begin
                    ctrl.regs.reg_write  = 1'b1;
                    ctrl.regs.reg_dst    = DST_RA;
                    ctrl.regs.mem_to_reg = WD_ALUOUT;
                    ctrl.pc.pc_write     = 1'b1;
                    ctrl.pc.branch       = 1'b1;
                    ctrl.pc.pc_src       = PC_SRC_JUMP;
                end
                ST_JR: begin
                    ctrl.alu.src_a   = SRC_A_REG;
                    ctrl.alu.op      = ALU_PASS;
                    ctrl.pc.pc_src   = PC_SRC_ALU;
                    ctrl.pc.branch   = 1'b1;
                    ctrl.pc.pc_write = 1'b1;
                end
                ST_EXC_ILLEGAL, ST_EXC_OVERFLOW: begin
                    ctrl.except    = (state == ST_EXC_OVERFLOW) ? EXC_OVERFLOW : EXC_ILLEGAL;
                    ctrl.mem.iord  = IORD_VECTOR;
                    ctrl.alu.src_a = SRC_A_PC;
                    ctrl.alu.src_b = SRC_B_FOUR;
                    ctrl.alu.op    = ALU_SUB;       // PC - 4 for EPC
                end
                ST_EXC_COMMIT: begin
                    ctrl.regs.epc_write = 1'b1;
                    ctrl.pc.pc_src      = PC_SRC_VECTOR;
                    ctrl.pc.pc_write    = 1'b1;
                end
                default: ctrl = IDLE_WORD;          // Dispatch drives nothing
            endcase
        end
    end

endmodule

/* control_unit.sv */
module control_unit import ctrl_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic [5:0] opcode,
    input  logic [5:0] funct,
    input  logic       ov,
    output ctrl_word_t ctrl
);

    decoded_op_t dec_op;
    decoded_op_t held_op;
    state_t      state;

    ctrl_decode decode_i (
        .opcode (opcode),
        .funct  (funct),
        .op     (dec_op)
    );

    ctrl_sequencer sequencer_i (
        .clk    (clk),
        .reset  (reset),
        .dec_op (dec_op),
        .ov     (ov),
        .state  (state),
        .op     (held_op)
    );

    ctrl_outputs outputs_i (
        .reset  (reset),
        .state  (state),
        .op     (held_op),
        .ctrl   (ctrl)
    );

endmodule

/* tb_clock.sv */
module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;      // Period 4
        end
    end

endmodule

/* control_unit_tb.sv */
module control_unit_tb import ctrl_pkg::*; ();

    localparam int unsigned RESET_CYCLES   = 16;
    localparam int unsigned TIMEOUT_CYCLES = 16 + 20 * 12 * 2;

    logic       clk;
    logic       reset;
    logic [5:0] opcode;
    logic [5:0] funct;
    logic       ov;
    ctrl_word_t ctrl;

    int unsigned errors;
    int unsigned checks;
    int unsigned tests;
    int unsigned cycles;
    ctrl_word_t  exp_q[$];      // One expected word per cycle of the instruction

    tb_clock clock_i (.clk(clk));

    control_unit dut_i (
        .clk    (clk),
        .reset  (reset),
        .opcode (opcode),
        .funct  (funct),
        .ov     (ov),
        .ctrl   (ctrl)
    );

    task automatic check_field(input string sig, input logic [15:0] exp_v,
                               input logic [15:0] act_v);
        if (act_v !== exp_v) begin
            $display("ERR %0t %s expected %h actual %h", $time, sig, exp_v, act_v);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input int unsigned cycle, input ctrl_word_t w);
        string at;
        at = $sformatf(" (%s, cycle %0d)", name, cycle);
        checks++;
        check_field({"ctrl.pc", at}, w.pc, ctrl.pc);
        check_field({"ctrl.mem", at}, w.mem, ctrl.mem);
        check_field({"ctrl.alu", at}, w.alu, ctrl.alu);
        check_field({"ctrl.regs", at}, w.regs, ctrl.regs);
        check_field({"ctrl.except", at}, w.except, ctrl.except);
    endtask

    // Memory read at PC, ALU forming PC + 4
    function automatic ctrl_word_t fetch_word();
        ctrl_word_t w;
        w           = '0;
        w.mem.iord  = IORD_PC;
        w.alu.src_a = SRC_A_PC;
        w.alu.src_b = SRC_B_FOUR;
        w.alu.op    = ALU_ADD;
        return w;
    endfunction

    // Fetch wait, fetch done, decode and dispatch
    task automatic push_prefix();
        ctrl_word_t w;
        exp_q.delete();
        repeat (FETCH_WAIT) exp_q.push_back(fetch_word());
        w               = fetch_word();
        w.pc.pc_write   = 1'b1;
        w.regs.ir_write = 1'b1;
        exp_q.push_back(w);
        w              = '0;
        w.regs.a_write = 1'b1;
        w.regs.b_write = 1'b1;
        exp_q.push_back(w);
        w = '0;
        exp_q.push_back(w);
    endtask

    task automatic push_exception(input except_t code);
        ctrl_word_t w;
        w           = '0;
        w.except    = code;
        w.mem.iord  = IORD_VECTOR;
        w.alu.src_a = SRC_A_PC;
        w.alu.src_b = SRC_B_FOUR;
        w.alu.op    = ALU_SUB;
        repeat (EXC_WAIT) exp_q.push_back(w);
        w                = '0;
        w.regs.epc_write = 1'b1;
        w.pc.pc_src      = PC_SRC_VECTOR;
        w.pc.pc_write    = 1'b1;
        exp_q.push_back(w);
    endtask

    // Entered on the falling edge of the first fetch cycle, left on the next one
    task automatic run_instr(input string name, input logic [5:0] opc, input logic [5:0] fn,
                             input logic ov_in);
        int unsigned bad_before;
        int unsigned i;
        bad_before = errors;
        opcode     = opc;
        funct      = fn;
        ov         = ov_in;
        for (i = 0; i < exp_q.size(); i++) begin
            if (i > 0) begin
                @(negedge clk);
            end
            #1;
            check_word(name, i + 1, exp_q[i]);
        end
        @(negedge clk);
        tests++;
        $display("test %s: %0d cycles, %0d mismatches", name, exp_q.size(), errors - bad_before);
    endtask

    // The last instruction hands back to fetch up to the next fetch done
    task automatic verify_return_to_fetch();
        ctrl_word_t  w;
        int unsigned i;
        int unsigned bad_before;
        bad_before = errors;
        w          = fetch_word();
        for (i = 0; i < FETCH_WAIT; i++) begin
            if (i > 0) begin
                @(negedge clk);
            end
            #1;
            check_word("return to fetch", i + 1, w);
        end
        @(negedge clk);
        #1;
        w.pc.pc_write   = 1'b1;
        w.regs.ir_write = 1'b1;
        check_word("return to fetch", FETCH_WAIT + 1, w);
        tests++;
        $display("test return to fetch: %0d mismatches", errors - bad_before);
    endtask

    task automatic reset_test();
        ctrl_word_t  w;
        int unsigned i;
        w                 = '0;
        w.regs.reg_write  = 1'b1;
        w.regs.reg_dst    = DST_SP;
        w.regs.mem_to_reg = WD_SP_INIT;
        for (i = 1; i < RESET_CYCLES; i++) begin
            @(negedge clk);
            #1;
            check_word("reset", i, w);
        end
        @(negedge clk);
        reset = 1'b0;           // This cycle is the first fetch
        tests++;
        $display("test reset: %0d mismatches", errors);
    endtask

    task automatic test_alu(input string name, input logic [5:0] opc, input logic [5:0] fn,
                            input alu_op_t aop, input logic ov_in);
        ctrl_word_t w;
        push_prefix();
        w                   = '0;
        w.alu.src_a         = SRC_A_REG;
        w.alu.src_b         = (opc == OP_RTYPE) ? SRC_B_REG : SRC_B_IMM;
        w.alu.op            = aop;
        w.alu.alu_out_write = 1'b1;
        exp_q.push_back(w);
        if (ov_in && opc != OP_ADDIU) begin      // addiu never traps
            push_exception(EXC_OVERFLOW);
        end else begin
            w                 = '0;
            w.regs.reg_write  = 1'b1;
            w.regs.reg_dst    = (opc == OP_RTYPE) ? DST_RD : DST_RT;
            w.regs.mem_to_reg = WD_ALUOUT;
            exp_q.push_back(w);
        end
        run_instr(name, opc, fn, ov_in);
    endtask

    task automatic test_mem(input string name, input logic [5:0] opc, input access_size_t size,
                            input logic is_load);
        ctrl_word_t w;
        push_prefix();
        w                   = '0;
        w.alu.src_a         = SRC_A_REG;
        w.alu.src_b         = SRC_B_IMM;
        w.alu.op            = ALU_ADD;
        w.alu.alu_out_write = 1'b1;
        exp_q.push_back(w);
        w          = '0;
        w.mem.iord = IORD_ALUOUT;
        repeat (MEM_WAIT) exp_q.push_back(w);
        if (is_load) begin
            w.mem.mem_to_mdr = size;
            w.regs.mdr_write = 1'b1;
            exp_q.push_back(w);
            w                 = '0;
            w.regs.reg_write  = 1'b1;
            w.regs.reg_dst    = DST_RT;
            w.regs.mem_to_reg = WD_MDR;
        end else begin
            w.mem.mem_wr = 1'b1;
            w.mem.b_to_c = size;
        end
        exp_q.push_back(w);
        run_instr(name, opc, 6'h00, 1'b0);
    endtask

    task automatic test_jump(input string name, input logic [5:0] opc, input logic [5:0] fn);
        ctrl_word_t w;
        push_prefix();
        w = '0;
        if (opc == OP_JAL) begin
            w.alu.src_a         = SRC_A_PC;
            w.alu.op            = ALU_PASS;
            w.alu.alu_out_write = 1'b1;
            exp_q.push_back(w);
            w                 = '0;
            w.regs.reg_write  = 1'b1;
            w.regs.reg_dst    = DST_RA;
            w.regs.mem_to_reg = WD_ALUOUT;
        end
        w.pc.pc_write = 1'b1;
        w.pc.branch   = 1'b1;
        if (opc == OP_RTYPE) begin
            w.pc.pc_src = PC_SRC_ALU;       // jr target from register A
            w.alu.src_a = SRC_A_REG;
            w.alu.op    = ALU_PASS;
        end else begin
            w.pc.pc_src = PC_SRC_JUMP;
        end
        exp_q.push_back(w);
        run_instr(name, opc, fn, 1'b0);
    endtask

    task automatic test_illegal(input string name, input logic [5:0] opc, input logic [5:0] fn);
        push_prefix();
        push_exception(EXC_ILLEGAL);
        run_instr(name, opc, fn, 1'b0);
    endtask

    initial begin
        logic ov_pick;
        reset  = 1'b1;
        opcode = '0;
        funct  = '0;
        ov     = 1'b0;
        errors = 0;
        checks = 0;
        tests  = 0;
        void'($urandom(32'hc1c8_5942));

        reset_test();
        test_alu("add", OP_RTYPE, FN_ADD, ALU_ADD, 1'b0);
        test_alu("sub", OP_RTYPE, FN_SUB, ALU_SUB, 1'b0);
        test_alu("and", OP_RTYPE, FN_AND, ALU_AND, 1'b0);
        test_alu("addi", OP_ADDI, 6'h00, ALU_ADD, 1'b0);
        test_alu("addiu", OP_ADDIU, 6'h00, ALU_ADD, 1'b0);
        test_alu("addiu with ov", OP_ADDIU, 6'h00, ALU_ADD, 1'b1);
        test_alu("add with ov", OP_RTYPE, FN_ADD, ALU_ADD, 1'b1);
        test_alu("sub with ov", OP_RTYPE, FN_SUB, ALU_SUB, 1'b1);
        test_alu("addi with ov", OP_ADDI, 6'h00, ALU_ADD, 1'b1);
        test_mem("lw", OP_LW, SZ_WORD, 1'b1);
        test_mem("lh", OP_LH, SZ_HALF, 1'b1);
        test_mem("lb", OP_LB, SZ_BYTE, 1'b1);
        test_mem("sw", OP_SW, SZ_WORD, 1'b0);
        test_mem("sh", OP_SH, SZ_HALF, 1'b0);
        test_mem("sb", OP_SB, SZ_BYTE, 1'b0);
        test_jump("j", OP_J, 6'h00);
        test_jump("jal", OP_JAL, 6'h00);
        test_jump("jr", OP_RTYPE, FN_JR);
        test_illegal("unknown opcode", 6'h3f, 6'h00);
        test_illegal("unknown funct", OP_RTYPE, 6'h3f);
        repeat (3) begin
            ov_pick = 1'($urandom() % 2);
            test_alu($sformatf("add, ov %0b", ov_pick), OP_RTYPE, FN_ADD, ALU_ADD, ov_pick);
            ov_pick = 1'($urandom() % 2);
            test_alu($sformatf("addi, ov %0b", ov_pick), OP_ADDI, 6'h00, ALU_ADD, ov_pick);
        end
        verify_return_to_fetch();

        $display("Summary: %0d tests, %0d checks, %0d mismatches", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Limit from the longest instruction and the number of tests
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* list.f */
ctrl_pkg.sv
ctrl_decode.sv
ctrl_sequencer.sv
ctrl_outputs.sv
control_unit.sv
tb_clock.sv
control_unit_tb.sv
